// File: src/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    localparam int imem_depth = 256;
    localparam int imem_aw = $clog2(imem_depth);
    localparam int dmem_depth = 256;
    localparam int dmem_aw = $clog2(dmem_depth);

    // Major opcodes, bits [6:0] of the instruction.
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [31:0] inst_ebreak = 32'h0010_0073;

    // Load and store sizes as encoded in funct3.
    localparam logic [2:0] f3_byte   = 3'b000;
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_t;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       src_a_pc;  // Operand a is pc instead of rs1.
        logic       src_b_imm; // Operand b is the immediate instead of rs2.
        logic       reg_wen;
        logic       mem_ren;
        logic       mem_wen;
        logic       branch;
        logic       jal;
        logic       jalr;
        logic       ebreak;
        logic       illegal;
        logic [2:0] funct3;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
        logic [4:0]      rd;
        logic            wen;
        logic [xlen-1:0] wdata;
    } retire_t;

endpackage

// File: src/ifu.sv
`timescale 1ns/1ns

module ifu import rv_pkg::*; (
    input  logic               clk,
    input  logic               imem_we,
    input  logic [imem_aw-1:0] imem_addr,
    input  logic [31:0]        imem_wdata,
    input  logic [xlen-1:0]    pc,
    output logic [31:0]        inst
);

    logic [31:0]        mem [imem_depth];
    logic [xlen-1:0]    offset;
    logic [imem_aw-1:0] word_idx;

    // The program window starts at the reset pc and wraps every imem_depth words.
    assign offset   = pc - reset_pc;
    assign word_idx = offset[imem_aw+1:2];
    assign inst     = mem[word_idx];

    always_ff @(posedge clk) begin
        if (imem_we) begin
            mem[imem_addr] <= imem_wdata;
        end
    end

    // A JALR to a target with bit 1 set would land here misaligned.
    a_pc_aligned: assert property (
        @(posedge clk) !$isunknown(pc) |-> pc[1:0] == 2'b00
    ) else $error("pc %h is not word aligned", pc);

endmodule

// File: src/idu.sv
`timescale 1ns/1ns

module idu import rv_pkg::*; (
    input  logic [31:0]     inst,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    output logic [4:0]      rd,
    output logic [xlen-1:0] imm,
    output ctrl_t           ctrl
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic            legal;

    // Shared by OP and OP-IMM; alt selects SUB and SRA.
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  arith_op = alt ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = alt ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.funct3 = funct3;
        ctrl.alu_op = alu_add;
        imm         = imm_i;
        legal       = 1'b1;
        case (opcode)
            op_lui: begin
                imm            = imm_u;
                ctrl.alu_op    = alu_pass_b;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_wen   = 1'b1;
            end
            op_auipc, op_jal: begin
                imm            = (opcode == op_jal) ? imm_j : imm_u;
                ctrl.src_a_pc  = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_wen   = 1'b1;
                ctrl.jal       = (opcode == op_jal);
            end
            op_jalr: begin
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_wen   = 1'b1;
                ctrl.jalr      = 1'b1;
                legal          = (funct3 == 3'b000);
            end
            op_branch: begin
                imm            = imm_b; // The ALU forms the target pc + imm.
                ctrl.src_a_pc  = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.branch    = 1'b1;
                legal          = (funct3 != 3'b010) && (funct3 != 3'b011);
            end
            op_load: begin
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_wen   = 1'b1;
                ctrl.mem_ren   = 1'b1;
                legal          = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
            end
            op_store: begin
                imm            = imm_s;
                ctrl.src_b_imm = 1'b1;
                ctrl.mem_wen   = 1'b1;
                legal          = (funct3[2] == 1'b0) && (funct3 != 3'b011);
            end
            op_imm: begin
                ctrl.alu_op    = arith_op(funct3, (funct3 == 3'b101) && inst[30]);
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_wen   = 1'b1;
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end
            end
            op_op: begin
                ctrl.alu_op  = arith_op(funct3, inst[30]);
                ctrl.reg_wen = 1'b1;
                legal = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            op_system: begin
                ctrl.ebreak = (inst == inst_ebreak);
                legal       = (inst == inst_ebreak);
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            ctrl         = '0; // Unknown encodings retire as no-ops.
            ctrl.funct3  = funct3;
            ctrl.illegal = 1'b1;
        end
    end

endmodule

// File: src/exu.sv
`timescale 1ns/1ns

module exu import rv_pkg::*; (
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] rs1_value,
    input  logic [xlen-1:0] rs2_value,
    input  ctrl_t           ctrl,
    output logic [xlen-1:0] result,
    output logic            take_branch
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic            cond;

    assign op_a  = ctrl.src_a_pc ? pc : rs1_value;
    assign op_b  = ctrl.src_b_imm ? imm : rs2_value;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = op_a - op_b;
            alu_sll:    result = op_a << shamt;
            alu_slt:    result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   result = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:    result = op_a ^ op_b;
            alu_srl:    result = op_a >> shamt;
            alu_sra:    result = $unsigned($signed(op_a) >>> shamt);
            alu_or:     result = op_a | op_b;
            alu_and:    result = op_a & op_b;
            alu_pass_b: result = op_b; // LUI.
            default:    result = op_a + op_b;
        endcase
    end

    // Branch conditions always compare the register values, never the operands.
    always_comb begin
        case (ctrl.funct3)
            f3_beq:  cond = (rs1_value == rs2_value);
            f3_bne:  cond = (rs1_value != rs2_value);
            f3_blt:  cond = ($signed(rs1_value) < $signed(rs2_value));
            f3_bge:  cond = ($signed(rs1_value) >= $signed(rs2_value));
            f3_bltu: cond = (rs1_value < rs2_value);
            f3_bgeu: cond = (rs1_value >= rs2_value);
            default: cond = 1'b0;
        endcase
    end

    assign take_branch = ctrl.branch && cond;

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ns

module reg_file import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic            wen,
    input  logic [xlen-1:0] wdata,
    output logic [xlen-1:0] rs1_value,
    output logic [xlen-1:0] rs2_value,
    output logic [xlen-1:0] a0_value
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_value = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign a0_value  = regs[10]; // Used as the trap value.

    a_x0_zero: assert property (
        @(posedge clk) rst_n |=> regs[0] == '0
    ) else $error("x0 holds %h", regs[0]);

endmodule

// File: src/lsu.sv
`timescale 1ns/1ns

module lsu import rv_pkg::*; (
    input  logic            clk,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] store_data,
    input  logic [2:0]      funct3,
    input  logic            wen,
    input  logic            ren,
    output logic [xlen-1:0] load_data
);

    logic [xlen-1:0]    mem [dmem_depth];
    logic [dmem_aw-1:0] idx;
    logic [xlen-1:0]    word;
    logic [xlen-1:0]    shifted;
    logic [3:0]         wmask;
    logic [xlen-1:0]    wword;

    assign idx     = addr[dmem_aw+1:2]; // High address bits are ignored, so accesses wrap.
    assign word    = mem[idx];
    assign shifted = word >> {addr[1:0], 3'b000};

    always_comb begin
        case (funct3)
            f3_byte:   load_data = {{24{shifted[7]}}, shifted[7:0]};
            f3_half:   load_data = {{16{shifted[15]}}, shifted[15:0]};
            f3_byte_u: load_data = {24'b0, shifted[7:0]};
            f3_half_u: load_data = {16'b0, shifted[15:0]};
            default:   load_data = word;
        endcase
        if (!ren) begin
            load_data = '0;
        end
    end

    // Replicate the store data so that every lane holds a copy, then mask.
    always_comb begin
        case (funct3[1:0])
            2'b00: begin
                wmask = 4'b0001 << addr[1:0];
                wword = {4{store_data[7:0]}};
            end
            2'b01: begin
                wmask = 4'b0011 << addr[1:0];
                wword = {2{store_data[15:0]}};
            end
            default: begin
                wmask = 4'b1111;
                wword = store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) mem[idx][8*b +: 8] <= wword[8*b +: 8];
            end
        end
    end

    a_aligned: assert property (
        @(posedge clk) (wen || ren) |->
            (funct3[1:0] == 2'b00) ||
            (funct3[1:0] == 2'b01 && addr[0] == 1'b0) ||
            (funct3[1:0] == 2'b10 && addr[1:0] == 2'b00)
    ) else $error("misaligned access at %h, funct3 %b", addr, funct3);

endmodule

// File: src/cpu_core.sv
`timescale 1ns/1ns

module cpu_core import rv_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               imem_we,
    input  logic [imem_aw-1:0] imem_addr,
    input  logic [31:0]        imem_wdata,
    output logic [xlen-1:0]    pc,
    output retire_t            retire,
    output logic               halted,
    output logic [xlen-1:0]    trap_value
);

    logic [31:0]     inst;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] imm;
    ctrl_t           ctrl;
    logic [xlen-1:0] rs1_value;
    logic [xlen-1:0] rs2_value;
    logic [xlen-1:0] a0_value;
    logic [xlen-1:0] result;
    logic            take_branch;
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] wb_value;
    logic            active;
    logic            reg_wen;

    assign active   = rst_n && !halted; // One instruction retires in every active cycle.
    assign reg_wen  = ctrl.reg_wen && active;
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        if (ctrl.jalr) begin
            next_pc = {result[xlen-1:1], 1'b0};
        end else if (ctrl.jal || take_branch) begin
            next_pc = result;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_comb begin
        if (ctrl.jal || ctrl.jalr) begin
            wb_value = pc_plus4; // Link address.
        end else if (ctrl.mem_ren) begin
            wb_value = load_data;
        end else begin
            wb_value = result;
        end
    end

    // On EBREAK the pc stays on the EBREAK itself.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= reset_pc;
            halted <= 1'b0;
        end else if (active) begin
            if (ctrl.ebreak) begin
                halted <= 1'b1;
            end else begin
                pc <= next_pc;
            end
        end
    end

    always_comb begin
        retire.valid = active;
        retire.pc    = pc;
        retire.inst  = inst;
        retire.rd    = rd;
        retire.wen   = reg_wen;
        retire.wdata = wb_value;
    end

    assign trap_value = a0_value;

    ifu ifu_inst0 (
        .clk        (clk),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .pc         (pc),
        .inst       (inst)
    );

    idu idu_inst0 (
        .inst (inst),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .imm  (imm),
        .ctrl (ctrl)
    );

    reg_file reg_file_inst0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .wen       (reg_wen),
        .wdata     (wb_value),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .a0_value  (a0_value)
    );

    exu exu_inst0 (
        .pc          (pc),
        .imm         (imm),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .ctrl        (ctrl),
        .result      (result),
        .take_branch (take_branch)
    );

    lsu lsu_inst0 (
        .clk        (clk),
        .addr       (result),
        .store_data (rs2_value),
        .funct3     (ctrl.funct3),
        .wen        (ctrl.mem_wen && active),
        .ren        (ctrl.mem_ren && active),
        .load_data  (load_data)
    );

    a_halt_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) halted |=> halted && !retire.valid
    ) else $error("instruction retired after halt");

    a_no_illegal: assert property (
        @(posedge clk) disable iff (!rst_n) retire.valid |-> !ctrl.illegal
    ) else $error("illegal instruction %h at pc %h", inst, pc);

endmodule

// File: test/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Reference state. Data memory survives resets, as it does in the core.
logic [31:0] m_imem [imem_depth];
logic [31:0] m_regs [32];
logic [31:0] m_dmem [dmem_depth];
logic [31:0] m_pc;
logic        m_halted;
logic [31:0] prog [$];

function automatic int rnd(int n);
    return int'($urandom % n);
endfunction

function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_op};
endfunction

function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
endfunction

function automatic logic [31:0] s_type(int off, int rs1, int rs2, int f3);
    return {off[11:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:0], op_store};
endfunction

function automatic logic [31:0] b_type(int off, int rs1, int rs2, int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], op_branch};
endfunction

function automatic logic [31:0] u_type(int imm, int rd, logic [6:0] op);
    return {imm[19:0], rd[4:0], op};
endfunction

function automatic logic [31:0] j_type(int off, int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
endfunction

function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                        logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        default: return a >= b;
    endcase
endfunction

task automatic model_reset();
    for (int i = 0; i < 32; i++) begin
        m_regs[5'(i)] = '0;
    end
    m_pc     = reset_pc;
    m_halted = 1'b0;
endtask

// Executes the instruction at m_pc and returns what the core should retire for it.
task automatic model_step(output retire_t exp);
    logic [31:0] ioff;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] addr;
    logic [31:0] sh;
    logic [31:0] mask;
    logic [31:0] next_pc;
    logic [2:0]  f3;
    logic [4:0]  lane;
    ioff    = m_pc - reset_pc;
    inst    = m_imem[ioff[imem_aw+1:2]];
    f3      = inst[14:12];
    a       = m_regs[inst[19:15]];
    b       = m_regs[inst[24:20]];
    imm_i   = {{20{inst[31]}}, inst[31:20]};
    imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u   = {inst[31:12], 12'b0};
    imm_j   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    next_pc = m_pc + 32'd4;
    exp       = '0;
    exp.valid = 1'b1;
    exp.pc    = m_pc;
    exp.inst  = inst;
    exp.rd    = inst[11:7];
    exp.wen   = 1'b1;
    case (inst[6:0])
        op_lui:   exp.wdata = imm_u;
        op_auipc: exp.wdata = m_pc + imm_u;
        op_jal: begin
            exp.wdata = m_pc + 32'd4;
            next_pc   = m_pc + imm_j;
        end
        op_jalr: begin
            exp.wdata = m_pc + 32'd4;
            next_pc   = (a + imm_i) & ~32'd1;
        end
        op_branch: begin
            exp.wen = 1'b0;
            if (branch_ref(f3, a, b)) begin
                next_pc = m_pc + imm_b;
            end
        end
        op_load: begin
            addr = a + imm_i;
            sh   = m_dmem[addr[dmem_aw+1:2]] >> {addr[1:0], 3'b000};
            case (f3)
                3'd0:    exp.wdata = {{24{sh[7]}}, sh[7:0]};
                3'd1:    exp.wdata = {{16{sh[15]}}, sh[15:0]};
                3'd4:    exp.wdata = {24'b0, sh[7:0]};
                3'd5:    exp.wdata = {16'b0, sh[15:0]};
                default: exp.wdata = sh;
            endcase
        end
        op_store: begin
            exp.wen = 1'b0;
            addr    = a + imm_s;
            lane    = {addr[1:0], 3'b000};
            mask    = (f3 == 3'd0) ? 32'h0000_00ff : (f3 == 3'd1) ? 32'h0000_ffff : '1;
            m_dmem[addr[dmem_aw+1:2]] = (m_dmem[addr[dmem_aw+1:2]] & ~(mask << lane)) |
                                        ((b & mask) << lane);
        end
        op_imm: exp.wdata = alu_ref(f3, f3 == 3'd5 && inst[30], a, imm_i);
        op_op:  exp.wdata = alu_ref(f3, inst[30], a, b);
        default: begin // Only EBREAK is ever generated here.
            exp.wen  = 1'b0;
            m_halted = 1'b1;
            next_pc  = m_pc;
        end
    endcase
    if (exp.wen && exp.rd != 5'd0) begin
        m_regs[exp.rd] = exp.wdata;
    end
    m_pc = next_pc;
endtask

task automatic alu_program(int n);
    int f3;
    int imm;
    prog.delete();
    for (int i = 0; i < n; i++) begin
        f3 = rnd(8);
        case (rnd(4))
            0: prog.push_back(u_type(rnd(1 << 20), rnd(32), op_lui));
            1: prog.push_back(u_type(rnd(1 << 20), rnd(32), op_auipc));
            2: prog.push_back(r_type((f3 == 0 || f3 == 5) ? 32 * rnd(2) : 0,
                                     rnd(32), rnd(32), f3, rnd(32)));
            default: begin
                imm = rnd(4096);
                if (f3 == 1) begin
                    imm = rnd(32);
                end else if (f3 == 5) begin
                    imm = rnd(32) + 1024 * rnd(2); // Bit 10 selects SRAI.
                end
                prog.push_back(i_type(imm, rnd(32), f3, rnd(32), op_imm));
            end
        endcase
    end
    prog.push_back(inst_ebreak);
endtask

task automatic mem_program(int n);
    int f3;
    int off;
    prog.delete();
    // Fill the first 16 words so that no load sees unwritten data.
    for (int k = 0; k < 16; k++) begin
        prog.push_back(u_type(rnd(1 << 20), 1, op_lui));
        prog.push_back(i_type(rnd(4096), 1, 0, 1, op_imm));
        prog.push_back(s_type(4 * k, 0, 1, 2));
    end
    for (int r = 2; r < 8; r++) begin
        prog.push_back(u_type(rnd(1 << 20), r, op_lui));
    end
    for (int i = 0; i < n; i++) begin
        f3  = rnd(3);
        off = (rnd(64) & ~((1 << f3) - 1)) + 1024 * rnd(2); // 1024 wraps to the same word.
        if (rnd(2) == 1) begin
            prog.push_back(s_type(off, 0, rnd(8), f3));
        end else begin
            if (f3 < 2) begin
                f3 += 4 * rnd(2);
            end
            prog.push_back(i_type(off, 0, f3, 1 + rnd(31), op_load));
        end
    end
    prog.push_back(inst_ebreak);
endtask

task automatic branch_program(int n);
    int last;
    int i;
    int f3;
    int rr;
    int step;
    bit targeted [imem_depth];
    prog.delete();
    targeted = '{default: 1'b0};
    for (int r = 1; r < 8; r++) begin
        prog.push_back(i_type(rnd(16) - 8, 0, 0, r, op_imm)); // Small values give equal operands.
    end
    last = prog.size() + n;
    while (prog.size() < last) begin
        i = prog.size();
        case (rnd(5))
            0: begin
                f3 = rnd(6);
                if (f3 >= 2) begin
                    f3 += 2;
                end
                step = 1 + rnd(last - i);
                targeted[i + step] = 1'b1;
                prog.push_back(b_type(4 * step, 1 + rnd(7), 1 + rnd(7), f3));
            end
            1: begin
                step = 1 + rnd(last - i);
                targeted[i + step] = 1'b1;
                prog.push_back(j_type(4 * step, rnd(32)));
            end
            2: begin
                // A jump onto the JALR would skip the AUIPC that sets its base.
                if (i + 3 <= last && !targeted[i + 1]) begin
                    rr = 8 + rnd(8);
                    prog.push_back(u_type(0, rr, op_auipc));
                    prog.push_back(i_type(12 + rnd(2), rr, 0, rnd(32), op_jalr));
                    prog.push_back(i_type(rnd(4096), 0, 0, 1 + rnd(7), op_imm)); // Skipped.
                end
            end
            default: begin
                rr = 1 + rnd(7);
                prog.push_back(i_type(rnd(8) - 4, rr, 0, rr, op_imm));
            end
        endcase
    end
    prog.push_back(inst_ebreak);
endtask

task automatic halt_program(logic nonzero);
    prog.delete();
    prog.push_back(i_type(rnd(4096), 0, 0, 11, op_imm));
    if (nonzero) begin
        prog.push_back(u_type(1 + rnd((1 << 20) - 1), 10, op_lui));
        prog.push_back(i_type(rnd(4096), 10, 0, 10, op_imm));
    end else begin
        prog.push_back(i_type(0, 0, 0, 10, op_imm));
    end
    prog.push_back(inst_ebreak);
endtask

`endif

// File: test/tb_cpu_core.sv
`timescale 1ns/1ns

module tb_cpu_core import rv_pkg::*; ();

    logic               clk;
    logic               rst_n;
    logic               imem_we;
    logic [imem_aw-1:0] imem_addr;
    logic [31:0]        imem_wdata;
    logic [xlen-1:0]    pc;
    retire_t            retire;
    logic               halted;
    logic [xlen-1:0]    trap_value;

    int errors;
    int tests_run;
    int tests_failed;

    `include "tb_model.svh"

    cpu_core UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .pc         (pc),
        .retire     (retire),
        .halted     (halted),
        .trap_value (trap_value)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_word(string name, logic [xlen-1:0] got, logic [xlen-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_retire(retire_t got, retire_t exp);
        check_flag("retire.valid", got.valid, exp.valid);
        check_word("retire.pc", got.pc, exp.pc);
        check_word("retire.inst", got.inst, exp.inst);
        check_word("retire.rd", {27'b0, got.rd}, {27'b0, exp.rd});
        check_flag("retire.wen", got.wen, exp.wen);
        if (exp.wen) begin
            check_word("retire.wdata", got.wdata, exp.wdata); // Undefined without a write.
        end
    endtask

    // Loads prog during reset, then runs it against the model up to and past EBREAK.
    task automatic run_test(string name);
        retire_t exp;
        int      errs_before;
        int      len;
        int      cycles;
        int      waited;
        errs_before = errors;
        foreach (prog[i]) begin
            m_imem[8'(i)] = prog[i];
        end
        model_reset();
        len = (prog.size() > 8) ? prog.size() : 8;
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            rst_n     <= 1'b0;
            imem_addr <= 8'(i);
            if (i < prog.size()) begin
                imem_we    <= 1'b1;
                imem_wdata <= prog[i];
            end else begin
                imem_we <= 1'b0;
            end
            @(negedge clk);
            check_flag("retire.valid", retire.valid, 1'b0);
        end
        @(posedge clk);
        rst_n   <= 1'b1;
        imem_we <= 1'b0;
        @(negedge clk);
        check_word("pc", pc, reset_pc);
        check_flag("halted", halted, 1'b0);

        cycles = 0;
        while (!m_halted && errors == errs_before && cycles < prog.size() + 4) begin
            model_step(exp);
            check_retire(retire, exp);
            cycles++;
            @(negedge clk);
        end
        if (!m_halted && errors == errs_before) begin
            $display("%s did not reach EBREAK within %0d cycles", name, cycles);
            errors++;
        end

        waited = 0;
        while (!halted && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        if (!halted) begin
            $display("%s: core did not halt within 16 cycles", name);
            errors++;
        end else begin
            if (m_halted && waited != 0) begin
                $display("%s: halted rose %0d cycles late after EBREAK", name, waited);
                errors++;
            end
            for (int k = 0; k < 4; k++) begin
                check_flag("halted", halted, 1'b1);
                check_flag("retire.valid", retire.valid, 1'b0);
                check_word("pc", pc, m_pc);
                check_word("trap_value", trap_value, m_regs[10]);
                @(negedge clk);
            end
        end

        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
        end
        $display("%-18s %s, %0d instructions retired", name,
                 (errors == errs_before) ? "passed" : "FAILED", cycles);
    endtask

    initial begin
        rst_n        = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(50711));

        alu_program(60);
        run_test("alu_random_0");
        alu_program(80);
        run_test("alu_random_1");
        alu_program(100);
        run_test("alu_random_2");
        mem_program(80);
        run_test("mem_random_0");
        mem_program(120);
        run_test("mem_random_1");
        branch_program(60);
        run_test("branch_jump_0");
        branch_program(90);
        run_test("branch_jump_1");
        halt_program(1'b0);
        run_test("ebreak_a0_zero");
        halt_program(1'b1);
        run_test("ebreak_a0_nonzero");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #1_000_000;
        $display("Simulation did not finish within its time limit");
        $display("Test failures found");
        $finish;
    end

endmodule

// File: flist.f
+incdir+test
src/rv_pkg.sv
src/ifu.sv
src/idu.sv
src/exu.sv
src/reg_file.sv
src/lsu.sv
src/cpu_core.sv
test/tb_cpu_core.sv

// File: Makefile
# Verilator build and run for the RV32I core testbench.

VERILATOR ?= verilator
TOP       ?= tb_cpu_core
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= All tests passed!

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard test/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BUILD_DIR)/V%: $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FLIST) -Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
